//--- Bender.yml
package:
  name: ucstats

sources:
  - files:
      - logic/ucstats_pkg.sv
      - logic/uc_bus_sync.sv
      - logic/uc_beat_counter.sv
      - logic/uc_xfer_fsm.sv
      - logic/uc_xfer_regs.sv
      - logic/stat_bank_ctrl.sv
      - logic/stat_ram_banks.sv
      - logic/ucstats_top.sv
  - target: test
    files:
      - tests/ucstats_chk.sv
      - tests/ucstats_tb.sv

//--- logic/stat_bank_ctrl.sv
// bank swap control for the double buffered stat RAM
// a swap waits while a link engine read is open, req to done
`default_nettype none

module stat_bank_ctrl (
   input  logic clk,
   input  logic uc_rst_n,
   input  logic ram_wr,
   input  logic interval_mark,
   input  logic le_req,
   input  logic le_done,
   output logic uc_bank,
   output logic gnt
);

   ucstats_pkg::bank_state_t state;
   ucstats_pkg::bank_state_t state_nxt;
   logic                     reading_q;
   logic                     le_busy;

   // req counts as open already in its first cycle
   assign le_busy = reading_q | le_req;

   always_comb begin
      case (state)
         ucstats_pkg::bank_idle:
            state_nxt = ram_wr ? ucstats_pkg::bank_writing : ucstats_pkg::bank_idle;
         ucstats_pkg::bank_writing:
            state_nxt = interval_mark ? ucstats_pkg::bank_interval_done
                                      : ucstats_pkg::bank_writing;
         // hold off the swap during a read, a fresh write restarts the interval
         ucstats_pkg::bank_interval_done:
            state_nxt = le_busy ? ucstats_pkg::bank_interval_done :
                        ram_wr  ? ucstats_pkg::bank_writing : ucstats_pkg::bank_update;
         default:
            state_nxt = ucstats_pkg::bank_idle;
      endcase
   end

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state     <= ucstats_pkg::bank_idle;
         uc_bank   <= 1'b0;
         reading_q <= 1'b0;
         gnt       <= 1'b0;
      end else begin
         state <= state_nxt;
         // new bank is live for the whole update state
         if (state_nxt == ucstats_pkg::bank_update) begin
            uc_bank <= ~uc_bank;
         end
         if (le_req) begin
            reading_q <= 1'b1;
         end else if (le_done) begin
            reading_q <= 1'b0;
         end
         gnt <= le_req;
      end
   end

endmodule

`default_nettype wire

//--- logic/stat_ram_banks.sv
// two 1024x32 banks with registered reads, no reset on contents
// uc writes and reads its own bank, the link engine reads the other
// le_data follows le_addr by two cycles
`default_nettype none

module stat_ram_banks (
   input  logic                           clk,
   input  logic                           uc_rst_n,
   input  logic                           uc_bank,
   input  logic                           ram_wr,
   input  logic [ucstats_pkg::ram_aw-1:0] uc_ram_addr,
   input  logic [ucstats_pkg::ram_aw-1:0] le_addr,
   input  logic [ucstats_pkg::word_w-1:0] wr_word,
   output logic [ucstats_pkg::word_w-1:0] uc_rd_word,
   output logic [ucstats_pkg::word_w-1:0] le_data
);

   localparam int depth = 1 << ucstats_pkg::ram_aw;

   logic [ucstats_pkg::word_w-1:0] rd_q [2];

   for (genvar b = 0; b < 2; b++) begin : bank_g
      logic [ucstats_pkg::word_w-1:0] mem [depth];
      logic [ucstats_pkg::ram_aw-1:0] rd_addr;
      logic                           is_uc;

      assign is_uc   = (uc_bank == 1'(b));
      assign rd_addr = is_uc ? uc_ram_addr : le_addr;

      always_ff @(posedge clk) begin
         if (ram_wr && is_uc) begin
            mem[uc_ram_addr] <= wr_word;
         end
         rd_q[b] <= mem[rd_addr];
      end
   end

   assign uc_rd_word = rd_q[uc_bank];

   // second stage of the link engine read
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         le_data <= '0;
      end else begin
         le_data <= rd_q[!uc_bank];
      end
   end

endmodule

`default_nettype wire

//--- logic/uc_beat_counter.sv
// byte beat counter, wraps after one word
// clear wins over step
`default_nettype none

module uc_beat_counter (
   input  logic       clk,
   input  logic       uc_rst_n,
   input  logic       clear,
   input  logic       step,
   output logic [1:0] beat,
   output logic       last_beat
);

   assign last_beat = (beat == 2'(ucstats_pkg::beats_per_word - 1));

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         beat <= 2'd0;
      end else if (clear) begin
         beat <= 2'd0;
      end else if (step) begin
         beat <= last_beat ? 2'd0 : beat + 2'd1;
      end
   end

endmodule

`default_nettype wire

//--- logic/uc_bus_sync.sv
// all uc inputs are asynchronous and pass two flops
// strobe edges appear 3 cycles after the pin toggles
`default_nettype none

module uc_bus_sync (
   input  logic                           clk,
   input  logic                           uc_rst_n,
   input  logic                           cs,
   input  logic                           valid,
   input  logic                           master,
   input  logic [ucstats_pkg::byte_w-1:0] data_in,
   output logic                           cs_s,
   output logic                           master_s,
   output logic                           valid_rise,
   output logic                           valid_fall,
   output logic [ucstats_pkg::byte_w-1:0] data_s
);

   localparam int sync_w = ucstats_pkg::byte_w + 3;

   logic [sync_w-1:0] meta_q;
   logic [sync_w-1:0] sync_q;
   logic              valid_s;
   logic              valid_d;

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         meta_q  <= '0;
         sync_q  <= '0;
         valid_d <= 1'b0;
      end else begin
         meta_q  <= {cs, valid, master, data_in};
         sync_q  <= meta_q;
         // delay flop for edge detect
         valid_d <= valid_s;
      end
   end

   assign {cs_s, valid_s, master_s, data_s} = sync_q;

   // single cycle pulses
   assign valid_rise = valid_s & ~valid_d;
   assign valid_fall = ~valid_s & valid_d;

endmodule

`default_nettype wire

//--- logic/uc_xfer_fsm.sv
// sequences uc address, write, read and drive phases
// a cs drop mid-phase ends in early_done, between words or after a read in done
// the address phase counts both strobe edges, data and drive count one
`default_nettype none

module uc_xfer_fsm (
   input  logic clk,
   input  logic uc_rst_n,
   input  logic cs_s,
   input  logic master_s,
   input  logic valid_rise,
   input  logic valid_fall,
   input  logic last_beat,
   input  logic addr_invalid,
   input  logic addr_is_write,
   input  logic addr_is_mark,
   output logic beat_clear,
   output logic beat_step,
   output logic take_addr,
   output logic take_data,
   output logic ram_wr,
   output logic ram_rd,
   output logic drive,
   output logic interval_mark
);

   ucstats_pkg::uc_state_t state;
   ucstats_pkg::uc_state_t state_nxt;

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state <= ucstats_pkg::uc_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt     = state;
      beat_clear    = 1'b0;
      beat_step     = 1'b0;
      take_addr     = 1'b0;
      take_data     = 1'b0;
      ram_wr        = 1'b0;
      ram_rd        = 1'b0;
      drive         = 1'b0;
      interval_mark = 1'b0;
      case (state)
         ucstats_pkg::uc_idle: begin
            // one step at cs start puts the address bytes on beats 1 and 3
            beat_clear = !cs_s;
            beat_step  = cs_s;
            state_nxt  = cs_s ? ucstats_pkg::uc_addr : ucstats_pkg::uc_idle;
         end
         ucstats_pkg::uc_addr: begin
            take_addr = valid_rise;
            beat_step = valid_rise | valid_fall;
            if (valid_rise && last_beat) begin
               state_nxt = ucstats_pkg::uc_addr_dec;
            end
         end
         ucstats_pkg::uc_addr_dec: begin
            beat_clear = 1'b1;
            // invalid read skips the RAM, the bad word is already loaded
            if (addr_invalid) begin
               state_nxt = addr_is_write ? ucstats_pkg::uc_invalid_wr
                                         : ucstats_pkg::uc_rd_wait_fall;
            end else begin
               state_nxt = addr_is_write ? ucstats_pkg::uc_wr_data
                                         : ucstats_pkg::uc_rd_ram;
            end
         end
         // wr_next is the gap between words, cs may end the write there
         ucstats_pkg::uc_wr_data, ucstats_pkg::uc_wr_next: begin
            take_data = valid_rise;
            beat_step = valid_rise;
            if (valid_rise) begin
               state_nxt = last_beat ? ucstats_pkg::uc_wr_ram : ucstats_pkg::uc_wr_data;
            end
         end
         ucstats_pkg::uc_wr_ram: begin
            // marker word closes the interval and is not stored
            ram_wr        = !addr_is_mark;
            interval_mark = addr_is_mark;
            state_nxt     = ucstats_pkg::uc_wr_next;
         end
         ucstats_pkg::uc_rd_ram: begin
            ram_rd    = 1'b1;
            state_nxt = ucstats_pkg::uc_rd_wait_fall;
         end
         // strobe falls first, only then is master trusted
         ucstats_pkg::uc_rd_wait_fall: begin
            state_nxt = valid_fall ? ucstats_pkg::uc_rd_wait_master : state;
         end
         ucstats_pkg::uc_rd_wait_master: begin
            state_nxt = master_s ? state : ucstats_pkg::uc_rd_drive;
         end
         ucstats_pkg::uc_rd_drive: begin
            // never drive once the bus is no longer ours
            drive     = cs_s && !master_s;
            beat_step = valid_fall;
            if (valid_fall && last_beat) begin
               state_nxt = ucstats_pkg::uc_rd_done;
            end
         end
         // both wait for cs to drop
         ucstats_pkg::uc_rd_done, ucstats_pkg::uc_invalid_wr: begin
            state_nxt = state;
         end
         ucstats_pkg::uc_early_done, ucstats_pkg::uc_done: begin
            beat_clear = 1'b1;
            state_nxt  = ucstats_pkg::uc_idle;
         end
         default: begin
            state_nxt = ucstats_pkg::uc_error;
         end
      endcase

      // --------------------------------------------------
      // cs negation
      // --------------------------------------------------
      if (!cs_s) begin
         if (state inside {ucstats_pkg::uc_wr_next, ucstats_pkg::uc_rd_done,
                           ucstats_pkg::uc_invalid_wr}) begin
            state_nxt = ucstats_pkg::uc_done;
         end else if (state inside {ucstats_pkg::uc_addr, ucstats_pkg::uc_addr_dec,
                                    ucstats_pkg::uc_wr_data, ucstats_pkg::uc_rd_ram,
                                    ucstats_pkg::uc_rd_wait_fall,
                                    ucstats_pkg::uc_rd_wait_master,
                                    ucstats_pkg::uc_rd_drive}) begin
            state_nxt = ucstats_pkg::uc_early_done;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/uc_xfer_regs.sv
// uc address, write data and read data registers with address decode
// address bytes arrive on beats 1 and 3, data bytes on beats 0 to 3
// data_out is only meaningful while data_out_val is high
`default_nettype none

module uc_xfer_regs (
   input  logic                           clk,
   input  logic                           uc_rst_n,
   input  logic [ucstats_pkg::byte_w-1:0] data_s,
   input  logic [1:0]                     beat,
   input  logic                           take_addr,
   input  logic                           take_data,
   input  logic                           ram_wr,
   input  logic                           ram_rd,
   input  logic                           addr_dec_bad_load,
   input  logic                           drive,
   input  logic [ucstats_pkg::word_w-1:0] uc_rd_word,
   output logic                           addr_invalid,
   output logic                           addr_is_write,
   output logic                           addr_is_mark,
   output logic [ucstats_pkg::ram_aw-1:0] uc_ram_addr,
   output logic [ucstats_pkg::word_w-1:0] wr_word,
   output logic [ucstats_pkg::byte_w-1:0] data_out,
   output logic                           data_out_val
);

   logic [ucstats_pkg::uc_addr_w-1:0] uc_addr;
   logic [ucstats_pkg::word_w-1:0]    rd_word;
   logic [1:0]                        space;

   // --------------------------------------------------
   // address, low byte first
   // --------------------------------------------------
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         uc_addr <= '0;
      end else if (take_addr) begin
         // beat 1 is the low byte, beat 3 the high byte
         uc_addr[beat[1]*ucstats_pkg::byte_w +: ucstats_pkg::byte_w] <= data_s;
      end else if (ram_wr) begin
         // auto increment for the next word of a burst
         uc_addr <= uc_addr + 1'b1;
      end
   end

   assign uc_ram_addr = uc_addr[ucstats_pkg::ram_aw-1:0];

   // write word assembled byte by byte
   always_ff @(posedge clk) begin
      if (take_data) begin
         wr_word[beat*ucstats_pkg::byte_w +: ucstats_pkg::byte_w] <= data_s;
      end
   end

   // --------------------------------------------------
   // decode
   // --------------------------------------------------
   assign space         = uc_addr[11:10];
   assign addr_is_write = uc_addr[ucstats_pkg::addr_wr_bit];
   assign addr_is_mark  = addr_is_write && (space == ucstats_pkg::space_fpga)
                          && (uc_addr[ucstats_pkg::ram_aw-1:0] == ucstats_pkg::interval_mark_ofs);
   // reserved field set, or FPGA space other than the marker write
   assign addr_invalid  = (|uc_addr[14:11])
                          || ((space != ucstats_pkg::space_stat) && !addr_is_mark);

   // --------------------------------------------------
   // read word and byte select
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (addr_dec_bad_load) begin
         rd_word <= ucstats_pkg::bad_read_word;
      end else if (ram_rd) begin
         rd_word <= uc_rd_word;
      end
   end

   assign data_out     = rd_word[beat*ucstats_pkg::byte_w +: ucstats_pkg::byte_w];
   assign data_out_val = drive;

endmodule

`default_nettype wire

//--- logic/ucstats_pkg.sv
// widths, address map and state encodings shared by the uc stats path
// one stat space of 32 SFPs x 32 words; the FPGA space holds only the marker
`default_nettype none

package ucstats_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int byte_w         = 8;
   localparam int word_w         = 32;
   // 1024 words, SFP select in [9:5]
   localparam int ram_aw         = 10;
   localparam int uc_addr_w      = 16;
   localparam int beats_per_word = 4;

   // --------------------------------------------------
   // uc address map
   // --------------------------------------------------
   // bit 15 set means write, [11:10] picks the space
   localparam int addr_wr_bit = 15;
   localparam logic [1:0] space_stat = 2'd0;
   localparam logic [1:0] space_fpga = 2'd1;
   // write here closes the collection interval
   localparam logic [ram_aw-1:0] interval_mark_ofs = 10'd1;
   // returned for any read outside the map
   localparam logic [word_w-1:0] bad_read_word = 32'hdead_beef;

   // transfer states, error only reachable from a corrupt encoding
   typedef enum logic [4:0] {
      uc_idle, uc_addr, uc_addr_dec,
      uc_wr_data, uc_wr_ram, uc_wr_next,
      uc_rd_ram, uc_rd_wait_fall, uc_rd_wait_master, uc_rd_drive, uc_rd_done,
      uc_invalid_wr, uc_early_done, uc_done,
      uc_error = 5'h1f
   } uc_state_t;

   typedef enum logic [1:0] {
      bank_idle, bank_writing, bank_interval_done, bank_update
   } bank_state_t;

endpackage

`default_nettype wire

//--- logic/ucstats_top.sv
// uc stats path, uc byte bus in and link engine stat reads out
// uc inputs may be asynchronous, the link engine runs on clk
`default_nettype none

module ucstats_top (
   input  logic                           clk,
   input  logic                           uc_rst_n,
   input  logic                           uc_cs,
   input  logic                           uc_valid,
   input  logic                           uc_master,
   input  logic [ucstats_pkg::byte_w-1:0] uc_data_in,
   output logic [ucstats_pkg::byte_w-1:0] uc_data_out,
   output logic                           uc_data_out_val,
   input  logic                           le_req,
   input  logic                           le_done,
   input  logic [ucstats_pkg::ram_aw-1:0] le_addr,
   output logic                           le_gnt,
   output logic [ucstats_pkg::word_w-1:0] le_data
);

   // --------------------------------------------------
   // internal wires
   // --------------------------------------------------
   logic                           cs_s, master_s, valid_rise, valid_fall;
   logic [ucstats_pkg::byte_w-1:0] data_s;
   logic                           beat_clear, beat_step, last_beat;
   logic [1:0]                     beat;
   logic                           take_addr, take_data, ram_wr, ram_rd;
   logic                           drive, interval_mark;
   logic                           addr_invalid, addr_is_write, addr_is_mark;
   logic [ucstats_pkg::ram_aw-1:0] uc_ram_addr;
   logic [ucstats_pkg::word_w-1:0] wr_word, uc_rd_word;
   logic                           uc_bank;

   uc_bus_sync sync_i (
      .clk, .uc_rst_n,
      .cs(uc_cs), .valid(uc_valid), .master(uc_master), .data_in(uc_data_in),
      .cs_s, .master_s, .valid_rise, .valid_fall, .data_s
   );

   uc_xfer_fsm fsm_i (
      .clk, .uc_rst_n,
      .cs_s, .master_s, .valid_rise, .valid_fall, .last_beat,
      .addr_invalid, .addr_is_write, .addr_is_mark,
      .beat_clear, .beat_step, .take_addr, .take_data,
      .ram_wr, .ram_rd, .drive, .interval_mark
   );

   uc_beat_counter beat_i (
      .clk, .uc_rst_n,
      .clear(beat_clear), .step(beat_step), .beat, .last_beat
   );

   // each address byte preloads the bad word, a valid read replaces it
   uc_xfer_regs regs_i (
      .clk, .uc_rst_n,
      .data_s, .beat, .take_addr, .take_data, .ram_wr, .ram_rd,
      .addr_dec_bad_load(take_addr), .drive, .uc_rd_word,
      .addr_invalid, .addr_is_write, .addr_is_mark,
      .uc_ram_addr, .wr_word,
      .data_out(uc_data_out), .data_out_val(uc_data_out_val)
   );

   stat_bank_ctrl bank_i (
      .clk, .uc_rst_n,
      .ram_wr, .interval_mark, .le_req, .le_done,
      .uc_bank, .gnt(le_gnt)
   );

   stat_ram_banks ram_i (
      .clk, .uc_rst_n,
      .uc_bank, .ram_wr, .uc_ram_addr, .le_addr, .wr_word,
      .uc_rd_word, .le_data
   );

endmodule

`default_nettype wire

//--- tb.f
logic/ucstats_pkg.sv
logic/uc_bus_sync.sv
logic/uc_beat_counter.sv
logic/uc_xfer_fsm.sv
logic/uc_xfer_regs.sv
logic/stat_bank_ctrl.sv
logic/stat_ram_banks.sv
logic/ucstats_top.sv
tests/ucstats_chk.sv
tests/ucstats_tb.sv

//--- tests/ucstats_chk.sv
// protocol checks on the uc bus and link engine handshake, bound into ucstats_top
// every failed assertion also bumps fail_cnt for the testbench summary
`default_nettype none

module ucstats_chk (
   input logic                   clk,
   input logic                   uc_rst_n,
   input logic                   cs_s,
   input logic                   master_s,
   input logic                   uc_data_out_val,
   input logic                   le_req,
   input logic                   le_gnt,
   input logic                   le_done,
   input ucstats_pkg::uc_state_t uc_state
);
   timeunit 1ns;
   timeprecision 100ps;

   int   fail_cnt = 0;
   logic read_open;

   // link engine read is open from req up to done
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         read_open <= 1'b0;
      end else if (le_req) begin
         read_open <= 1'b1;
      end else if (le_done) begin
         read_open <= 1'b0;
      end
   end

   // drive only while selected and after the master let go
   drive_bus_a: assert property (@(posedge clk) disable iff (!uc_rst_n)
      uc_data_out_val |-> (cs_s && !master_s))
      else begin
         fail_cnt++;
         $error("uc_data_out_val high while cs is low or master is high");
      end

   grant_a: assert property (@(posedge clk) disable iff (!uc_rst_n)
      le_gnt |-> $past(le_req))
      else begin
         fail_cnt++;
         $error("le_gnt high without le_req in the cycle before");
      end

   done_a: assert property (@(posedge clk) disable iff (!uc_rst_n)
      le_done |-> read_open)
      else begin
         fail_cnt++;
         $error("le_done high with no link engine read open");
      end

   // error state only follows a corrupt state encoding
   state_a: assert property (@(posedge clk) disable iff (!uc_rst_n)
      uc_state != ucstats_pkg::uc_error)
      else begin
         fail_cnt++;
         $error("transfer FSM reached its error state");
      end

endmodule

bind ucstats_top ucstats_chk chk_i (
   .clk,
   .uc_rst_n,
   .cs_s,
   .master_s,
   .uc_data_out_val,
   .le_req,
   .le_gnt,
   .le_done,
   .uc_state(fsm_i.state)
);

`default_nettype wire

//--- tests/ucstats_tb.sv
// testbench for the uc stats path, byte level uc bus and link engine reads
// uc bytes hold 6 cycles per strobe phase to pass the two-flop synchronizer
// RAM contents start unknown, so only written words are read back
`default_nettype none

module ucstats_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // --------------------------------------------------
   // run length, in clock cycles
   // --------------------------------------------------
   // a uc byte takes 14 cycles, a transfer adds about 12 around its bytes
   // reset 16, tests 1 to 6 about 10, 600, 800, 520, 220 and 180
   localparam int run_cycles      = 16 + 10 + 600 + 800 + 520 + 220 + 180;
   localparam int watchdog_cycles = run_cycles * 3 / 2;

   logic        clk = 1'b0;
   logic        uc_rst_n;
   logic        uc_cs;
   logic        uc_valid;
   logic        uc_master;
   logic [7:0]  uc_data_in;
   logic [7:0]  uc_data_out;
   logic        uc_data_out_val;
   logic        le_req;
   logic        le_done;
   logic [9:0]  le_addr;
   logic        le_gnt;
   logic [31:0] le_data;

   // reference model, two banks and the uc bank select
   logic [31:0] ref_mem [2][1024];
   logic        ref_bank;
   logic        swap_pending;
   logic        le_reading;
   logic [31:0] lfsr;
   int          errors;
   int          errs_at_start;
   int          tests_ok;
   int          tests_bad;
   int          total;

   always #5 clk = ~clk;

   ucstats_top dut_i (.*);

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------
   task automatic cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   // galois LFSR, one step per bit taken
   function automatic logic lfsr_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
         lfsr = lfsr ^ 32'hd000_0001;
      end
      return out;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      for (int i = 0; i < 32; i++) begin
         w[i] = lfsr_bit();
      end
      return w;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED %0t %s: got %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      int now_errs;
      now_errs = errors + dut_i.chk_i.fail_cnt;
      if (now_errs == errs_at_start) begin
         $display("test %s: ok", name);
         tests_ok++;
      end else begin
         $display("test %s: failed with %0d errors", name, now_errs - errs_at_start);
         tests_bad++;
      end
      errs_at_start = now_errs;
   endtask

   // --------------------------------------------------
   // uc bus
   // --------------------------------------------------
   // one valid pulse, rise then fall
   task automatic strobe();
      @(posedge clk);
      uc_valid <= 1'b1;
      cycles(6);
      uc_valid <= 1'b0;
      cycles(6);
   endtask

   // data settles a cycle ahead of the strobe
   task automatic send_byte(input logic [7:0] b);
      @(posedge clk);
      uc_data_in <= b;
      strobe();
   endtask

   task automatic uc_start(input logic [15:0] addr);
      @(posedge clk);
      uc_cs <= 1'b1;
      cycles(4);
      send_byte(addr[7:0]);
      send_byte(addr[15:8]);
   endtask

   task automatic uc_end();
      @(posedge clk);
      uc_cs     <= 1'b0;
      uc_master <= 1'b1;
      cycles(6);
   endtask

   // burst of n random words, only stat space with clear reserved bits stores
   task automatic uc_write(input logic [15:0] addr, input int n);
      logic [31:0] w;
      uc_start(addr);
      for (int i = 0; i < n; i++) begin
         w = rand_word();
         for (int b = 0; b < 4; b++) begin
            send_byte(w[8*b +: 8]);
         end
         if (addr[14:10] == 5'd0) begin
            ref_mem[ref_bank][addr[9:0] + 10'(i)] = w;
         end
      end
      uc_end();
   endtask

   // interval marker, the swap waits for an open link engine read
   task automatic uc_mark();
      uc_start(16'h8401);
      for (int b = 0; b < 4; b++) begin
         send_byte(8'h00);
      end
      uc_end();
      if (le_reading) begin
         swap_pending = 1'b1;
      end else begin
         ref_bank = !ref_bank;
      end
   endtask

   task automatic uc_read(input logic [15:0] addr);
      logic [31:0] exp;
      exp = (|addr[14:10]) ? 32'hdead_beef : ref_mem[ref_bank][addr[9:0]];
      uc_start(addr);
      // master still owns the bus here
      @(negedge clk);
      check_val("uc_data_out_val", uc_data_out_val, 32'd0);
      @(posedge clk);
      uc_master <= 1'b0;
      cycles(6);
      for (int b = 0; b < 4; b++) begin
         @(negedge clk);
         check_val("uc_data_out_val", uc_data_out_val, 32'd1);
         check_val("uc_data_out", uc_data_out, 32'(exp[8*b +: 8]));
         strobe();
      end
      uc_end();
   endtask

   // --------------------------------------------------
   // link engine
   // --------------------------------------------------
   task automatic le_open();
      logic seen;
      seen = 1'b0;
      @(posedge clk);
      le_req <= 1'b1;
      for (int i = 0; i < 8 && !seen; i++) begin
         @(negedge clk);
         seen = le_gnt;
      end
      if (!seen) begin
         $display("le_gnt did not follow le_req within 8 cycles at %0t", $time);
         errors++;
      end
      @(posedge clk);
      le_req     <= 1'b0;
      le_reading = 1'b1;
   endtask

   // one address per cycle, data due two cycles later
   task automatic le_burst(input logic [9:0] base, input int n);
      logic [31:0] exp [8];
      for (int k = 0; k < n; k++) begin
         exp[k] = ref_mem[!ref_bank][base + 10'(k)];
      end
      for (int k = 0; k < n + 2; k++) begin
         @(posedge clk);
         if (k < n) begin
            le_addr <= base + 10'(k);
         end
         @(negedge clk);
         if (k >= 2) begin
            check_val("le_data", le_data, exp[k-2]);
         end
      end
   endtask

   task automatic le_close();
      @(posedge clk);
      le_done <= 1'b1;
      @(posedge clk);
      le_done    <= 1'b0;
      le_reading = 1'b0;
      if (swap_pending) begin
         ref_bank     = !ref_bank;
         swap_pending = 1'b0;
      end
      cycles(3);
   endtask

   task automatic le_read(input logic [9:0] base, input int n);
      le_open();
      le_burst(base, n);
      le_close();
   endtask

   // --------------------------------------------------
   // tests
   // --------------------------------------------------
   initial begin
      uc_rst_n      = 1'b0;
      uc_cs         = 1'b0;
      uc_valid      = 1'b0;
      uc_master     = 1'b1;
      uc_data_in    = 8'h00;
      le_req        = 1'b0;
      le_done       = 1'b0;
      le_addr       = 10'd0;
      lfsr          = 32'h9e33_46bc;
      ref_bank      = 1'b0;
      swap_pending  = 1'b0;
      le_reading    = 1'b0;
      errors        = 0;
      errs_at_start = 0;
      tests_ok      = 0;
      tests_bad     = 0;
      cycles(16);
      uc_rst_n <= 1'b1;

      // le_data keeps its reset value until the first RAM read lands
      @(negedge clk);
      check_val("uc_data_out_val", uc_data_out_val, 32'd0);
      check_val("le_gnt", le_gnt, 32'd0);
      check_val("le_data", le_data, 32'd0);
      finish_test("reset values");

      // fill bank 0, swap with the link engine idle
      uc_write(16'h8040, 8);
      uc_mark();
      le_read(10'h040, 8);
      finish_test("write burst and link engine read");

      // bank 1 gets new words, after the swap uc reads see the first interval
      uc_write(16'h8040, 8);
      uc_mark();
      uc_read(16'h0042);
      uc_read(16'h0047);
      finish_test("uc read after swap");

      // reserved bit 12 set on read and on write
      uc_read(16'h1042);
      uc_write(16'h9043, 1);
      uc_write(16'h8050, 1);
      uc_mark();
      le_read(10'h043, 1);
      le_read(10'h050, 1);
      uc_read(16'h0043);
      finish_test("invalid address");

      // marker lands while a link engine read is open
      le_open();
      uc_write(16'h8044, 1);
      uc_mark();
      le_burst(10'h044, 1);
      le_close();
      le_read(10'h044, 1);
      finish_test("swap deferred by open read");

      // cs drops after two data bytes
      uc_start(16'h8045);
      send_byte(8'h11);
      send_byte(8'h22);
      uc_end();
      uc_read(16'h0045);
      finish_test("cut write");

      total = errors + dut_i.chk_i.fail_cnt;
      $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, total);
      if (tests_bad == 0 && total == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      cycles(watchdog_cycles);
      $display("timeout, run still busy after %0d cycles", watchdog_cycles);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
